// File: logic/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int WORD_W     = 32;
    localparam int HALF_W     = 16;
    localparam int EXT_ADDR_W = 22;    // halfword address on the external port

    // low two bits give the access size, bit 2 marks unsigned loads
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_t;

    typedef logic [1:0] beat_count_t;

    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_RAM  = 2'd1,
        REGION_EXT  = 2'd2
    } region_t;

    // index of the last beat, so one less than the number of beats
    function automatic beat_count_t beats_for(region_t region, ls_type_t ls_type);
        beat_count_t last;
        last = 2'd0;
        if (region == REGION_RAM) begin
            if (ls_type[1:0] == 2'b11) last = 2'd1;    // ld/sd take two words
        end else if (region == REGION_EXT) begin
            case (ls_type[1:0])
                2'b10:   last = 2'd1;
                2'b11:   last = 2'd3;
                default: last = 2'd0;
            endcase
        end
        return last;
    endfunction

    function automatic logic is_signed_load(ls_type_t ls_type);
        return !ls_type[2];
    endfunction

endpackage

// File: logic/beat_counter.sv
`timescale 1ns/1ps

module beat_counter import mem_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        count_start,
    input  beat_count_t beat_total,
    input  logic        count_advance,
    output beat_count_t beat_index,
    output logic        last_beat
);

    beat_count_t total_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_index <= 2'd0;
            total_q    <= 2'd0;
        end else if (count_start) begin
            beat_index <= 2'd0;
            total_q    <= beat_total;    // held for the whole access
        end else if (count_advance) begin
            beat_index <= beat_index + 2'd1;
        end
    end

    assign last_beat = (beat_index == total_q);

endmodule

// File: logic/word_ram.sv
`timescale 1ns/1ps

module word_ram import mem_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              CLOCK_50,
    input  logic [ADDR_W-3:0] ram_word_index,
    input  logic [WORD_W-1:0] ram_write_data,
    input  logic [3:0]        ram_byte_en,
    input  logic              ram_write,
    output logic [WORD_W-1:0] ram_read_data
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [WORD_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;

    // region decode keeps the index inside the array
    assign idx = ram_word_index[IDX_W-1:0];

    always_ff @(posedge CLOCK_50) begin
        if (ram_write) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_byte_en[b]) begin
                    mem[idx][8*b +: 8] <= ram_write_data[8*b +: 8];
                end
            end
        end
        ram_read_data <= mem[idx];    // old data on a same-cycle write
    end

endmodule

// File: logic/access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer import mem_bus_pkg::*; #(
    parameter logic [ADDR_W-1:0] RAM_BASE = 32'h0000_1000,
    parameter logic [ADDR_W-1:0] EXT_BASE = 32'h0100_0000
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic [ADDR_W-1:0]     bus_address,
    input  logic [DATA_W-1:0]     bus_write_data,
    input  ls_type_t              bus_ls_type,
    input  logic                  bus_read_enable,
    input  logic                  bus_write_enable,
    input  region_t               region,
    input  logic                  ext_wait,
    input  beat_count_t           beat_index,
    input  logic                  last_beat,
    output logic                  bus_read_done,
    output logic                  bus_write_done,
    output logic                  count_start,
    output logic                  count_advance,
    output logic [ADDR_W-3:0]     ram_word_index,
    output logic [WORD_W-1:0]     ram_write_data,
    output logic [3:0]            ram_byte_en,
    output logic                  ram_write,
    output logic [EXT_ADDR_W-1:0] ext_addr,
    output logic [1:0]            ext_byte_en,
    output logic                  ext_read_en,
    output logic                  ext_write_en,
    output logic [HALF_W-1:0]     ext_write_data,
    output logic                  capture,
    output beat_count_t           capture_beat
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT_BEAT,
        S_CAPTURE,
        S_FINISH
    } state_t;

    state_t            state;
    logic              op_read;
    logic              accept;
    logic              beat_done;
    logic [ADDR_W-1:0] ram_off;
    logic [ADDR_W-1:0] ext_off;

    // done flags are only both high in idle
    assign accept = (state == S_IDLE) && bus_read_done && bus_write_done
                    && (bus_read_enable || bus_write_enable);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= S_IDLE;
            op_read        <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        op_read <= bus_read_enable;    // read wins if both pulse
                        if (bus_read_enable) bus_read_done <= 1'b0;
                        else bus_write_done <= 1'b0;
                        state <= (region == REGION_NONE) ? S_FINISH : S_ISSUE;
                    end
                end
                S_ISSUE: state <= (region == REGION_EXT) ? S_WAIT_BEAT : S_CAPTURE;
                S_WAIT_BEAT: begin
                    if (!ext_wait) state <= last_beat ? S_FINISH : S_ISSUE;
                end
                S_CAPTURE: state <= last_beat ? S_FINISH : S_ISSUE;
                S_FINISH: begin
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                    state          <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // a beat ends on ram capture or when the external port stops waiting
    assign beat_done = (state == S_CAPTURE) || (state == S_WAIT_BEAT && !ext_wait);

    assign count_start   = accept;
    assign count_advance = beat_done;

    // unmapped reads load zero in finish
    assign capture = op_read && (beat_done || (state == S_FINISH && region == REGION_NONE));
    assign capture_beat = beat_index;

    assign ram_off = bus_address - RAM_BASE;
    assign ext_off = bus_address - EXT_BASE;

    assign ram_word_index = ram_off[ADDR_W-1:2] + (ADDR_W-2)'(beat_index);
    assign ram_write      = (state == S_ISSUE) && !op_read && (region == REGION_RAM);

    always_comb begin
        case (bus_ls_type[1:0])
            2'b00: begin
                ram_byte_en    = 4'b0001 << ram_off[1:0];
                ram_write_data = {4{bus_write_data[7:0]}};
            end
            2'b01: begin
                ram_byte_en    = 4'b0011 << {ram_off[1], 1'b0};
                ram_write_data = {2{bus_write_data[15:0]}};
            end
            default: begin
                ram_byte_en    = 4'b1111;
                ram_write_data = bus_write_data[{beat_index[0], 5'd0} +: WORD_W];
            end
        endcase
    end

    // external beat k sits k halfwords above the start
    assign ext_addr = ext_off[EXT_ADDR_W:1] + EXT_ADDR_W'(beat_index);

    always_comb begin
        if (bus_ls_type[1:0] == 2'b00) begin
            ext_byte_en    = bus_address[0] ? 2'b10 : 2'b01;
            ext_write_data = {2{bus_write_data[7:0]}};    // same byte on both lanes
        end else begin
            ext_byte_en    = 2'b11;
            ext_write_data = bus_write_data[{beat_index, 4'd0} +: HALF_W];
        end
    end

    assign ext_read_en  = (state == S_WAIT_BEAT) && op_read;
    assign ext_write_en = (state == S_WAIT_BEAT) && !op_read;

endmodule

// File: logic/load_assembler.sv
`timescale 1ns/1ps

module load_assembler import mem_bus_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              capture,
    input  beat_count_t       capture_beat,
    input  region_t           region,
    input  ls_type_t          bus_ls_type,
    input  logic [1:0]        byte_offset,
    input  logic [WORD_W-1:0] ram_read_data,
    input  logic [HALF_W-1:0] ext_read_data,
    output logic [DATA_W-1:0] bus_read_data
);

    logic [DATA_W-1:0] hold_q;
    logic [DATA_W-1:0] merged;
    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] extended;
    logic [4:0]        shift_amt;
    logic              sign_ext;
    logic              final_beat;

    // current beat dropped into its field, low beat first
    always_comb begin
        merged = hold_q;
        if (region == REGION_RAM) merged[{capture_beat[0], 5'd0} +: WORD_W] = ram_read_data;
        else merged[{capture_beat, 4'd0} +: HALF_W] = ext_read_data;
    end

    // external halfwords already sit in lane 0, only the odd byte moves
    assign shift_amt = (region == REGION_RAM) ? {byte_offset, 3'b000}
                                              : {1'b0, byte_offset[0], 3'b000};
    assign shifted   = merged >> shift_amt;
    assign sign_ext  = is_signed_load(bus_ls_type);

    always_comb begin
        case (bus_ls_type[1:0])
            2'b00: extended = {{56{sign_ext & shifted[7]}}, shifted[7:0]};
            2'b01: extended = {{48{sign_ext & shifted[15]}}, shifted[15:0]};
            2'b10: extended = {{32{sign_ext & shifted[31]}}, shifted[31:0]};
            default: extended = shifted;
        endcase
        if (region == REGION_NONE) extended = '0;    // unmapped reads zero
    end

    assign final_beat = (capture_beat == beats_for(region, bus_ls_type));

    always_ff @(posedge CLOCK_50) begin
        if (capture) hold_q <= merged;
    end

    // result only moves once the whole access is in
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_data <= '0;
        end else if (capture && final_beat) begin
            bus_read_data <= extended;
        end
    end

endmodule

// File: logic/mem_bus_bridge.sv
`timescale 1ns/1ps

module mem_bus_bridge import mem_bus_pkg::*; #(
    parameter logic [ADDR_W-1:0] RAM_BASE      = 32'h0000_1000,
    parameter int                RAM_WORDS     = 1024,
    parameter logic [ADDR_W-1:0] EXT_BASE      = 32'h0100_0000,
    parameter int                EXT_HALFWORDS = 4194304
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic [ADDR_W-1:0]     bus_address,
    input  logic [DATA_W-1:0]     bus_write_data,
    input  logic [2:0]            bus_ls_type,
    input  logic                  bus_read_enable,
    input  logic                  bus_write_enable,
    output logic [DATA_W-1:0]     bus_read_data,
    output logic                  bus_read_done,
    output logic                  bus_write_done,
    output logic [EXT_ADDR_W-1:0] ext_addr,
    output logic [1:0]            ext_byte_en,
    output logic                  ext_read_en,
    output logic                  ext_write_en,
    output logic [HALF_W-1:0]     ext_write_data,
    input  logic [HALF_W-1:0]     ext_read_data,
    input  logic                  ext_wait
);

    localparam logic [ADDR_W-1:0] RAM_END = RAM_BASE + ADDR_W'(RAM_WORDS * 4);
    localparam logic [ADDR_W-1:0] EXT_END = EXT_BASE + ADDR_W'(EXT_HALFWORDS * 2);

    ls_type_t          ls_type;
    region_t           region;
    beat_count_t       beat_total;
    beat_count_t       beat_index;
    logic              last_beat;
    logic              count_start;
    logic              count_advance;
    logic [ADDR_W-3:0] ram_word_index;
    logic [WORD_W-1:0] ram_write_data;
    logic [WORD_W-1:0] ram_read_data;
    logic [3:0]        ram_byte_en;
    logic              ram_write;
    logic              capture;
    beat_count_t       capture_beat;

    assign ls_type = ls_type_t'(bus_ls_type);

    always_comb begin
        region = REGION_NONE;
        if (bus_address >= RAM_BASE && bus_address < RAM_END) region = REGION_RAM;
        else if (bus_address >= EXT_BASE && bus_address < EXT_END) region = REGION_EXT;
    end

    assign beat_total = beats_for(region, ls_type);

    access_sequencer #(
        .RAM_BASE(RAM_BASE),
        .EXT_BASE(EXT_BASE)
    ) u_sequencer (
        .CLOCK_50, .KEY0, .bus_address, .bus_write_data,
        .bus_ls_type(ls_type),
        .bus_read_enable, .bus_write_enable, .region, .ext_wait,
        .beat_index, .last_beat, .bus_read_done, .bus_write_done,
        .count_start, .count_advance,
        .ram_word_index, .ram_write_data, .ram_byte_en, .ram_write,
        .ext_addr, .ext_byte_en, .ext_read_en, .ext_write_en, .ext_write_data,
        .capture, .capture_beat
    );

    beat_counter u_beat_counter (
        .CLOCK_50, .KEY0, .count_start, .beat_total, .count_advance,
        .beat_index, .last_beat
    );

    word_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_word_ram (
        .CLOCK_50, .ram_word_index, .ram_write_data, .ram_byte_en, .ram_write,
        .ram_read_data
    );

    load_assembler u_load_assembler (
        .CLOCK_50, .KEY0, .capture, .capture_beat, .region,
        .bus_ls_type(ls_type),
        .byte_offset(bus_address[1:0]),
        .ram_read_data, .ext_read_data, .bus_read_data
    );

endmodule

// File: sim/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model (
    input  logic        CLOCK_50,
    input  logic [21:0] ext_addr,
    input  logic [1:0]  ext_byte_en,
    input  logic        ext_read_en,
    input  logic        ext_write_en,
    input  logic [15:0] ext_write_data,
    input  logic        stall,           // wait request from the testbench generator
    output logic [15:0] ext_read_data,
    output logic        ext_wait
);

    logic [15:0] mem [256];
    logic [21:0] beat_addr [64];        // log of every finished beat
    logic [1:0]  beat_be [64];
    logic [5:0]  log_ptr = 6'd0;
    int          beat_total = 0;
    int          hold_errors = 0;
    logic        held = 1'b0;
    logic [41:0] beat_sig;
    logic [41:0] held_sig;

    initial begin
        for (int i = 0; i < 256; i++) mem[i] = 16'h0000;
    end

    assign ext_wait      = stall;
    assign ext_read_data = mem[ext_addr[7:0]];
    assign beat_sig      = {ext_read_en, ext_write_en, ext_byte_en, ext_addr, ext_write_data};

    always @(posedge CLOCK_50) begin
        // a stalled beat must look the same on the next edge
        if (held && held_sig !== beat_sig) begin
            hold_errors <= hold_errors + 1;
            $display("external beat changed while wait was high at %0t", $time);
        end
        held     <= (ext_read_en || ext_write_en) && ext_wait;
        held_sig <= beat_sig;
        if ((ext_read_en || ext_write_en) && !ext_wait) begin
            beat_addr[log_ptr] <= ext_addr;
            beat_be[log_ptr]   <= ext_byte_en;
            log_ptr            <= log_ptr + 6'd1;
            beat_total         <= beat_total + 1;
            if (ext_write_en && ext_byte_en[0]) mem[ext_addr[7:0]][7:0]  <= ext_write_data[7:0];
            if (ext_write_en && ext_byte_en[1]) mem[ext_addr[7:0]][15:8] <= ext_write_data[15:8];
        end
    end

endmodule

// File: sim/tb_mem_bus_bridge.sv
`timescale 1ns/1ps

module tb_mem_bus_bridge;

    localparam logic [31:0] RAM_BASE = 32'h0000_1000;
    localparam logic [31:0] EXT_BASE = 32'h0100_0000;
    localparam logic [31:0] UNMAPPED = 32'h0008_0000;
    localparam int NUM_ACC = 122;
    localparam time PERIOD = 100;

    logic        CLOCK_50 = 1'b0;
    logic        KEY0;
    logic [31:0] bus_address;
    logic [63:0] bus_write_data;
    logic [2:0]  bus_ls_type;
    logic        bus_read_enable;
    logic        bus_write_enable;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic        bus_write_done;
    logic [21:0] ext_addr;
    logic [1:0]  ext_byte_en;
    logic        ext_read_en;
    logic        ext_write_en;
    logic [15:0] ext_write_data;
    logic [15:0] ext_read_data;
    logic        ext_wait;
    logic        stall = 1'b0;

    logic [31:0] lfsr = 32'h3ab2;
    logic [7:0]  ram_sh [64];            // shadow of the ram window
    logic [7:0]  ext_sh [64];            // ext model starts zeroed
    int          data_errors = 0;
    int          handshake_errors = 0;
    logic        pending_valid = 1'b0;
    logic [63:0] pending_exp;
    string       pending_name;
    logic        prev_rd_done = 1'b1;

    mem_bus_bridge u_dut (.*);

    ext_mem_model u_ext (
        .CLOCK_50, .ext_addr, .ext_byte_en, .ext_read_en, .ext_write_en,
        .ext_write_data, .stall, .ext_read_data, .ext_wait
    );

    initial begin
        forever #(PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);    // galois step
        end
        return v;
    endfunction

    // expected load from the eight bytes at the address, low byte first
    function automatic logic [63:0] ref_load(input logic [63:0] raw, input logic [2:0] ls);
        case (ls)
            3'd0:    return {{56{raw[7]}}, raw[7:0]};
            3'd1:    return {{48{raw[15]}}, raw[15:0]};
            3'd2:    return {{32{raw[31]}}, raw[31:0]};
            3'd3:    return raw;
            3'd4:    return {56'd0, raw[7:0]};
            3'd5:    return {48'd0, raw[15:0]};
            3'd6:    return {32'd0, raw[31:0]};
            default: return 64'd0;
        endcase
    endfunction

    initial begin
        forever begin
            @(posedge CLOCK_50);
            #9;
            stall = 1'(rand_bits(1) & rand_bits(1));    // roughly one cycle in four
        end
    end

    // compare on each rising read done
    initial begin
        forever begin
            @(negedge CLOCK_50);
            if (bus_read_done && !prev_rd_done && pending_valid) begin
                if (bus_read_data !== pending_exp) begin
                    data_errors++;
                    $display("MISMATCH %s expected %h actual %h", pending_name, pending_exp,
                             bus_read_data);
                end
                pending_valid = 1'b0;
            end
            prev_rd_done = bus_read_done;
        end
    end

    task automatic do_access(input bit wr, input logic [31:0] addr, input logic [2:0] ls,
                             input logic [63:0] wd, input bit inject, input string name);
        int          n0;
        int          nb;
        int          off;
        int          size;
        bit          is_ram;
        bit          is_ext;
        logic [63:0] raw;
        logic [21:0] exp_addr;
        logic [1:0]  exp_be;
        logic [5:0]  idx;
        is_ram = (addr >= RAM_BASE) && (addr < RAM_BASE + 64);
        is_ext = (addr >= EXT_BASE) && (addr < EXT_BASE + 64);
        off    = is_ram ? int'(addr - RAM_BASE) : int'(addr - EXT_BASE);
        size   = 1 << ls[1:0];
        @(posedge CLOCK_50);
        #10;
        n0 = u_ext.beat_total;
        if (!wr) begin
            raw = 64'd0;
            for (int i = 0; i < size; i++) begin
                if (is_ram) raw[8*i +: 8] = ram_sh[off + i];
                if (is_ext) raw[8*i +: 8] = ext_sh[off + i];
            end
            pending_exp   = ref_load(raw, ls);
            pending_name  = name;
            pending_valid = 1'b1;
        end
        bus_address      = addr;
        bus_ls_type      = ls;
        bus_write_data   = wd;
        bus_read_enable  = !wr;
        bus_write_enable = wr;
        @(posedge CLOCK_50);
        #10;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        if (wr ? bus_write_done : bus_read_done) begin
            handshake_errors++;
            $display("%s: done flag did not fall after the enable", name);
        end
        if (inject) begin
            bus_read_enable  = wr;    // the opposite kind, while busy
            bus_write_enable = !wr;
            @(posedge CLOCK_50);
            #10;
            bus_read_enable  = 1'b0;
            bus_write_enable = 1'b0;
        end
        while (!(bus_read_done && bus_write_done)) @(negedge CLOCK_50);
        if (wr) begin
            for (int i = 0; i < size; i++) begin
                if (is_ram) ram_sh[off + i] = wd[8*i +: 8];
                if (is_ext) ext_sh[off + i] = wd[8*i +: 8];
            end
        end
        nb = !is_ext ? 0 : (ls[1:0] == 2'd3) ? 4 : (ls[1:0] == 2'd2) ? 2 : 1;
        if (u_ext.beat_total - n0 != nb) begin
            data_errors++;
            $display("MISMATCH %s beats expected %0d actual %0d", name, nb,
                     u_ext.beat_total - n0);
        end else begin
            for (int k = 0; k < nb; k++) begin
                idx      = 6'(n0 + k);
                exp_addr = 22'((addr - EXT_BASE) >> 1) + 22'(k);
                exp_be   = (ls[1:0] != 2'd0) ? 2'b11 : (addr[0] ? 2'b10 : 2'b01);
                if (u_ext.beat_addr[idx] !== exp_addr || u_ext.beat_be[idx] !== exp_be) begin
                    data_errors++;
                    $display("MISMATCH %s beat %0d expected %h/%b actual %h/%b", name, k,
                             exp_addr, exp_be, u_ext.beat_addr[idx], u_ext.beat_be[idx]);
                end
            end
        end
    endtask

    initial begin
        #(PERIOD * (200 * NUM_ACC + 1000));
        $display("timeout: the run did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic        wr;
        logic [2:0]  ls;
        logic [31:0] base;
        int          off;
        int          total;
        KEY0             = 1'b0;
        bus_address      = 32'd0;
        bus_write_data   = 64'd0;
        bus_ls_type      = 3'd0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        for (int i = 0; i < 64; i++) ext_sh[i] = 8'h00;
        repeat (3) @(posedge CLOCK_50);
        #10;
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        if (!bus_read_done || !bus_write_done || ext_read_en || ext_write_en) begin
            handshake_errors++;
            $display("bus or external handshake not idle after reset");
        end
        if (bus_read_data !== 64'd0) begin
            data_errors++;
            $display("MISMATCH reset_data expected %h actual %h", 64'd0, bus_read_data);
        end
        for (int i = 0; i < 8; i++) begin
            do_access(1'b1, RAM_BASE + 32'(8 * i), 3'd3, {rand_bits(32), rand_bits(32)},
                      1'b0, "ram_init");
            do_access(1'b1, EXT_BASE + 32'(8 * i), 3'd3, {rand_bits(32), rand_bits(32)},
                      1'b0, "ext_init");
        end
        for (int i = 0; i < 80; i++) begin
            base = i[0] ? EXT_BASE : RAM_BASE;
            wr   = 1'(rand_bits(1));
            ls   = wr ? {1'b0, 2'(rand_bits(2))} : 3'(rand_bits(3));
            if (ls == 3'd7) ls = 3'd3;
            off = int'(rand_bits(6)) & ~((1 << ls[1:0]) - 1);    // natural alignment
            do_access(wr, base + 32'(off), ls, {rand_bits(32), rand_bits(32)}, 1'b0,
                      i[0] ? "ext_mix" : "ram_mix");
        end
        do_access(1'b1, RAM_BASE + 24, 3'd3, 64'h8899_aabb_1122_3344, 1'b0, "ram_sd_double");
        do_access(1'b0, RAM_BASE + 24, 3'd3, 64'd0, 1'b0, "ram_ld_double");
        do_access(1'b1, EXT_BASE + 32, 3'd3, 64'hf00d_cafe_1357_9bdf, 1'b0, "ext_sd_double");
        do_access(1'b0, EXT_BASE + 32, 3'd3, 64'd0, 1'b0, "ext_ld_double");
        do_access(1'b1, UNMAPPED, 3'd3, {rand_bits(32), rand_bits(32)}, 1'b0, "unmapped_sd");
        do_access(1'b0, UNMAPPED, 3'd3, 64'd0, 1'b0, "unmapped_ld");
        for (int i = 0; i < 8; i++) begin
            do_access(1'b0, RAM_BASE + 32'(8 * i), 3'd3, 64'd0, 1'b0, "ram_reload");
            do_access(1'b0, EXT_BASE + 32'(8 * i), 3'd3, 64'd0, 1'b0, "ext_reload");
        end
        // a write pulse during a busy read must vanish
        do_access(1'b0, EXT_BASE + 16, 3'd3, {rand_bits(32), rand_bits(32)}, 1'b1,
                  "ext_busy_pulse");
        do_access(1'b0, RAM_BASE + 8, 3'd2, {rand_bits(32), rand_bits(32)}, 1'b1,
                  "ram_busy_pulse");
        do_access(1'b0, EXT_BASE + 16, 3'd3, 64'd0, 1'b0, "ext_after_pulse");
        do_access(1'b0, RAM_BASE + 8, 3'd3, 64'd0, 1'b0, "ram_after_pulse");
        repeat (2) @(posedge CLOCK_50);
        total = data_errors + handshake_errors + u_ext.hold_errors;
        $display("errors: data %0d handshake %0d hold %0d", data_errors, handshake_errors,
                 u_ext.hold_errors);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/mem_bus_pkg.sv
logic/beat_counter.sv
logic/word_ram.sv
logic/access_sequencer.sv
logic/load_assembler.sv
logic/mem_bus_bridge.sv
sim/ext_mem_model.sv
sim/tb_mem_bus_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_mem_bus_bridge \
    -f tb.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1
